// ==== src/dma_pkg.sv ====
package dma_pkg;

    localparam int NUM_CHANNELS = 4;

    typedef logic [NUM_CHANNELS-1:0] channel_mask_t;
    typedef logic [1:0]              channel_num_t;
    typedef logic [7:0]              data_t;
    typedef logic [1:0]              xfer_type_t;
    typedef logic [1:0]              xfer_mode_t;

    localparam xfer_type_t XFER_VERIFY = 2'b00;
    localparam xfer_type_t XFER_WRITE  = 2'b01;
    localparam xfer_type_t XFER_READ   = 2'b10;
    localparam xfer_type_t XFER_NONE   = 2'b11;

    // Encoding 2'b11 (cascade) is kept in the register and runs as demand
    localparam xfer_mode_t MODE_DEMAND = 2'b00;
    localparam xfer_mode_t MODE_SINGLE = 2'b01;
    localparam xfer_mode_t MODE_BLOCK  = 2'b10;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_S0,
        ST_S1,
        ST_S2,
        ST_S3,
        ST_WAIT,
        ST_S4
    } dma_state_t;

    // Command register bits
    localparam int CMD_COMPRESSED_BIT = 3;
    localparam int CMD_EXT_WRITE_BIT  = 5;
    localparam int CMD_DACK_HIGH_BIT  = 7;

    // Mode register fields
    localparam int MODE_CH_LSB   = 0;
    localparam int MODE_CH_MSB   = 1;
    localparam int MODE_TYPE_LSB = 2;
    localparam int MODE_TYPE_MSB = 3;
    localparam int MODE_MODE_LSB = 6;
    localparam int MODE_MODE_MSB = 7;

    function automatic channel_num_t mask_to_num(input channel_mask_t mask);
        channel_num_t num;
        num = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (mask[i]) begin
                num = channel_num_t'(i);
            end
        end
        return num;
    endfunction

endpackage

// ==== src/dma_config_regs.sv ====
module dma_config_regs (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   master_clear_i,
    input  dma_pkg::data_t         data_bus_i,
    input  logic                   write_command_i,
    input  logic                   write_mode_i,
    input  dma_pkg::channel_num_t  channel_i,
    output dma_pkg::xfer_type_t    xfer_type_o,
    output dma_pkg::xfer_mode_t    xfer_mode_o,
    output dma_pkg::channel_mask_t edge_request_o,
    output logic                   compressed_timing_o,
    output logic                   extended_write_o,
    output logic                   dack_high_o
);
    import dma_pkg::*;

    xfer_type_t type_q [NUM_CHANNELS];
    xfer_mode_t mode_q [NUM_CHANNELS];

    // Command register
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            compressed_timing_o <= 1'b0;
            extended_write_o    <= 1'b0;
            dack_high_o         <= 1'b0;
        end else if (master_clear_i) begin
            compressed_timing_o <= 1'b0;
            extended_write_o    <= 1'b0;
            dack_high_o         <= 1'b0;
        end else if (write_command_i) begin
            compressed_timing_o <= data_bus_i[CMD_COMPRESSED_BIT];
            extended_write_o    <= data_bus_i[CMD_EXT_WRITE_BIT];
            dack_high_o         <= data_bus_i[CMD_DACK_HIGH_BIT];
        end
    end

    // One mode register per channel, picked by the channel field
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_mode
        always_ff @(posedge clock, posedge reset) begin
            if (reset) begin
                type_q[ch] <= XFER_NONE;
                mode_q[ch] <= MODE_DEMAND;
            end else if (master_clear_i) begin
                type_q[ch] <= XFER_NONE;
                mode_q[ch] <= MODE_DEMAND;
            end else if (write_mode_i &&
                         (data_bus_i[MODE_CH_MSB:MODE_CH_LSB] == channel_num_t'(ch))) begin
                type_q[ch] <= data_bus_i[MODE_TYPE_MSB:MODE_TYPE_LSB];
                mode_q[ch] <= data_bus_i[MODE_MODE_MSB:MODE_MODE_LSB];
            end
        end

        // Single and block requests are latched by the priority block
        assign edge_request_o[ch] = (mode_q[ch] == MODE_SINGLE) || (mode_q[ch] == MODE_BLOCK);
    end

    assign xfer_type_o = type_q[channel_i];
    assign xfer_mode_o = mode_q[channel_i];

endmodule

// ==== src/dma_cycle_fsm.sv ====
module dma_cycle_fsm (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   master_clear_i,
    input  logic                   cpu_negedge_i,
    input  dma_pkg::channel_mask_t encoded_dma_i,
    input  dma_pkg::channel_mask_t dma_request_state_i,
    input  logic                   hold_acknowledge_i,
    input  logic                   ready_i,
    input  dma_pkg::xfer_type_t    xfer_type_i,
    input  dma_pkg::xfer_mode_t    xfer_mode_i,
    input  logic                   compressed_timing_i,
    input  logic                   end_of_process_i,
    output dma_pkg::dma_state_t    state_o,
    output dma_pkg::dma_state_t    next_state_o,
    output dma_pkg::channel_mask_t dack_mask_o,
    output dma_pkg::channel_num_t  channel_o,
    output dma_pkg::channel_num_t  dma_rotate_o,
    output logic                   next_word_o,
    output logic                   lock_bus_control_o
);
    import dma_pkg::*;

    logic ready_or_verify;
    logic request_dropped;
    logic demand_like;

    assign ready_or_verify = ready_i || (xfer_type_i == XFER_VERIFY);
    assign request_dropped = (dack_mask_o & dma_request_state_i) == '0;
    // Anything that is neither single nor block follows demand rules
    assign demand_like     = (xfer_mode_i != MODE_SINGLE) && (xfer_mode_i != MODE_BLOCK);

    always_comb begin
        next_state_o = state_o;
        case (state_o)
            ST_IDLE: begin
                if (encoded_dma_i != '0) next_state_o = ST_S0;
            end
            ST_S0: begin
                if (hold_acknowledge_i) next_state_o = ST_S1;
            end
            ST_S1: next_state_o = ST_S2;
            ST_S2: begin
                if (!compressed_timing_i) next_state_o = ST_S3;
                else if (ready_or_verify) next_state_o = ST_S4;
                else next_state_o = ST_WAIT;
            end
            ST_S3: begin
                next_state_o = ready_or_verify ? ST_S4 : ST_WAIT;
            end
            ST_WAIT: begin
                if (ready_i) next_state_o = ST_S4;
            end
            ST_S4: begin
                if (xfer_mode_i == MODE_SINGLE) next_state_o = ST_IDLE;
                else if (demand_like && request_dropped) next_state_o = ST_IDLE;
                else if (end_of_process_i) next_state_o = ST_IDLE;
                else next_state_o = ST_S2;
            end
            default: next_state_o = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state_o <= ST_IDLE;
        end else if (master_clear_i) begin
            state_o <= ST_IDLE;
        end else if (cpu_negedge_i) begin
            state_o <= next_state_o;
        end
    end

    // Winner is tracked until the cycle leaves idle
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            dack_mask_o  <= '0;
            dma_rotate_o <= 2'd3;
        end else if (master_clear_i) begin
            dack_mask_o  <= '0;
            dma_rotate_o <= 2'd3;
        end else begin
            if (state_o == ST_IDLE) dack_mask_o <= encoded_dma_i;
            if (state_o == ST_S0) dma_rotate_o <= channel_o;
        end
    end

    assign channel_o          = mask_to_num(dack_mask_o);
    assign next_word_o        = (next_state_o == ST_S4);
    assign lock_bus_control_o = (state_o != ST_IDLE);

endmodule

// ==== src/dma_end_of_process.sv ====
module dma_end_of_process (
    input  logic                clock,
    input  logic                reset,
    input  logic                master_clear_i,
    input  logic                cpu_posedge_i,
    input  logic                cpu_negedge_i,
    input  dma_pkg::dma_state_t state_i,
    input  dma_pkg::dma_state_t next_state_i,
    input  logic                next_word_i,
    input  logic                underflow_i,
    input  logic                end_of_process_n_i,
    output logic                end_of_process_o,
    output logic                end_of_process_n_o
);
    import dma_pkg::*;

    logic terminal_count;
    logic terminal_count_held;
    logic external_eop;

    // Pulse lasts one CPU period, held copy survives until S4
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            terminal_count      <= 1'b0;
            terminal_count_held <= 1'b0;
        end else if (master_clear_i) begin
            terminal_count      <= 1'b0;
            terminal_count_held <= 1'b0;
        end else if (cpu_posedge_i) begin
            if (state_i == ST_S4) begin
                terminal_count      <= 1'b0;
                terminal_count_held <= 1'b0;
            end else if (next_word_i) begin
                terminal_count      <= underflow_i;
                terminal_count_held <= underflow_i;
            end else begin
                terminal_count      <= 1'b0;
            end
        end
    end

    assign end_of_process_n_o = ~terminal_count;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            external_eop     <= 1'b0;
            end_of_process_o <= 1'b0;
        end else if (master_clear_i) begin
            external_eop     <= 1'b0;
            end_of_process_o <= 1'b0;
        end else if (cpu_negedge_i) begin
            if (state_i == ST_IDLE) external_eop <= 1'b0;
            else if ((next_state_i == ST_S2) && !end_of_process_n_i) external_eop <= 1'b1;
            // Flag is valid only while in S4
            end_of_process_o <= (next_state_i == ST_S4) && (terminal_count_held || external_eop);
        end
    end

endmodule

// ==== src/dma_bus_strobes.sv ====
module dma_bus_strobes (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   master_clear_i,
    input  logic                   cpu_posedge_i,
    input  logic                   cpu_negedge_i,
    input  dma_pkg::dma_state_t    state_i,
    input  dma_pkg::dma_state_t    next_state_i,
    input  dma_pkg::channel_mask_t dack_mask_i,
    input  dma_pkg::xfer_type_t    xfer_type_i,
    input  logic                   compressed_timing_i,
    input  logic                   extended_write_i,
    input  logic                   dack_high_i,
    output logic                   hold_request_o,
    output logic                   address_enable_o,
    output logic                   address_strobe_o,
    output dma_pkg::channel_mask_t dma_acknowledge_o,
    output logic                   memory_read_n_o,
    output logic                   memory_write_n_o,
    output logic                   io_read_n_io_o,
    output logic                   io_read_n_out_o,
    output logic                   io_write_n_io_o,
    output logic                   io_write_n_out_o
);
    import dma_pkg::*;

    channel_mask_t dack_q;
    logic          is_read;
    logic          is_write;
    logic          early_write;

    assign is_read     = (xfer_type_i == XFER_READ);
    assign is_write    = (xfer_type_i == XFER_WRITE);
    assign early_write = extended_write_i || compressed_timing_i;

    // Hold request and address outputs
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            hold_request_o   <= 1'b0;
            address_enable_o <= 1'b0;
            address_strobe_o <= 1'b0;
        end else if (master_clear_i) begin
            hold_request_o   <= 1'b0;
            address_enable_o <= 1'b0;
            address_strobe_o <= 1'b0;
        end else if (cpu_posedge_i) begin
            if (next_state_i == ST_S0) hold_request_o <= 1'b1;
            else if (next_state_i == ST_IDLE) hold_request_o <= 1'b0;
            if (state_i == ST_S1) address_enable_o <= 1'b1;
            else if (state_i == ST_IDLE) address_enable_o <= 1'b0;
            address_strobe_o <= (state_i == ST_S1);
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            dack_q <= '0;
        end else if (master_clear_i) begin
            dack_q <= '0;
        end else if (cpu_negedge_i) begin
            if (next_state_i == ST_S2) dack_q <= dack_mask_i;
            else if (next_state_i == ST_IDLE) dack_q <= '0;
        end
    end

    assign dma_acknowledge_o = dack_high_i ? dack_q : ~dack_q;

    // Read and write strobes, all active low
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            memory_read_n_o  <= 1'b1;
            memory_write_n_o <= 1'b1;
            io_read_n_io_o   <= 1'b1;
            io_read_n_out_o  <= 1'b1;
            io_write_n_io_o  <= 1'b1;
            io_write_n_out_o <= 1'b1;
        end else if (master_clear_i) begin
            memory_read_n_o  <= 1'b1;
            memory_write_n_o <= 1'b1;
            io_read_n_io_o   <= 1'b1;
            io_read_n_out_o  <= 1'b1;
            io_write_n_io_o  <= 1'b1;
            io_write_n_out_o <= 1'b1;
        end else if (cpu_posedge_i) begin
            // Early io variants span the whole grant
            if ((state_i == ST_S1) && is_write) io_read_n_io_o <= 1'b0;
            else if (state_i == ST_IDLE) io_read_n_io_o <= 1'b1;
            if ((state_i == ST_S1) && is_read) io_write_n_io_o <= 1'b0;
            else if (state_i == ST_IDLE) io_write_n_io_o <= 1'b1;

            if (state_i == ST_S4) begin
                memory_read_n_o  <= 1'b1;
                io_read_n_out_o  <= 1'b1;
                memory_write_n_o <= 1'b1;
                io_write_n_out_o <= 1'b1;
            end else begin
                if ((state_i == ST_S2) && is_read) memory_read_n_o <= 1'b0;
                if ((state_i == ST_S2) && is_write) io_read_n_out_o <= 1'b0;
                // Writes start one period later unless extended or compressed
                if ((state_i == ST_S3) || ((state_i == ST_S2) && early_write)) begin
                    if (is_read) io_write_n_out_o <= 1'b0;
                    if (is_write) memory_write_n_o <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== src/dma_timing_top.sv ====
module dma_timing_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   cpu_posedge_i,
    input  logic                   cpu_negedge_i,
    input  logic                   master_clear_i,
    input  dma_pkg::data_t         data_bus_i,
    input  logic                   write_command_i,
    input  logic                   write_mode_i,
    input  dma_pkg::channel_mask_t encoded_dma_i,
    input  dma_pkg::channel_mask_t dma_request_state_i,
    input  logic                   hold_acknowledge_i,
    input  logic                   ready_i,
    input  logic                   end_of_process_n_i,
    input  logic                   underflow_i,
    output logic                   hold_request_o,
    output dma_pkg::channel_mask_t dma_acknowledge_o,
    output logic                   address_enable_o,
    output logic                   address_strobe_o,
    output logic                   memory_read_n_o,
    output logic                   memory_write_n_o,
    output logic                   io_read_n_io_o,
    output logic                   io_read_n_out_o,
    output logic                   io_write_n_io_o,
    output logic                   io_write_n_out_o,
    output logic                   end_of_process_n_o,
    output logic                   next_word_o,
    output dma_pkg::channel_mask_t edge_request_o,
    output dma_pkg::channel_num_t  dma_rotate_o,
    output logic                   lock_bus_control_o
);
    import dma_pkg::*;

    channel_num_t  channel;
    channel_mask_t dack_mask;
    xfer_type_t    xfer_type;
    xfer_mode_t    xfer_mode;
    dma_state_t    state;
    dma_state_t    next_state;
    logic          compressed_timing;
    logic          extended_write;
    logic          dack_high;
    logic          end_of_process;

    dma_config_regs u_config (
        .clock, .reset, .master_clear_i, .data_bus_i, .write_command_i, .write_mode_i,
        .channel_i (channel), .xfer_type_o (xfer_type), .xfer_mode_o (xfer_mode),
        .edge_request_o, .compressed_timing_o (compressed_timing),
        .extended_write_o (extended_write), .dack_high_o (dack_high)
    );

    dma_cycle_fsm u_fsm (
        .clock, .reset, .master_clear_i, .cpu_negedge_i, .encoded_dma_i,
        .dma_request_state_i, .hold_acknowledge_i, .ready_i,
        .xfer_type_i (xfer_type), .xfer_mode_i (xfer_mode),
        .compressed_timing_i (compressed_timing), .end_of_process_i (end_of_process),
        .state_o (state), .next_state_o (next_state), .dack_mask_o (dack_mask),
        .channel_o (channel), .dma_rotate_o, .next_word_o, .lock_bus_control_o
    );

    dma_end_of_process u_eop (
        .clock, .reset, .master_clear_i, .cpu_posedge_i, .cpu_negedge_i,
        .state_i (state), .next_state_i (next_state), .next_word_i (next_word_o),
        .underflow_i, .end_of_process_n_i, .end_of_process_o (end_of_process),
        .end_of_process_n_o
    );

    dma_bus_strobes u_strobes (
        .clock, .reset, .master_clear_i, .cpu_posedge_i, .cpu_negedge_i,
        .state_i (state), .next_state_i (next_state), .dack_mask_i (dack_mask),
        .xfer_type_i (xfer_type), .compressed_timing_i (compressed_timing),
        .extended_write_i (extended_write), .dack_high_i (dack_high),
        .hold_request_o, .address_enable_o, .address_strobe_o, .dma_acknowledge_o,
        .memory_read_n_o, .memory_write_n_o, .io_read_n_io_o, .io_read_n_out_o,
        .io_write_n_io_o, .io_write_n_out_o
    );

endmodule

// ==== bench/dma_timing_checker.sv ====
module dma_timing_checker (
    input  logic                   clock,
    input  logic                   check_idle_i,
    input  dma_pkg::channel_num_t  exp_channel_i,
    input  logic                   exp_dack_high_i,
    input  int                     exp_mem_read_i,
    input  int                     exp_mem_write_i,
    input  int                     exp_io_read_i,
    input  int                     exp_io_write_i,
    input  int                     exp_eop_i,
    input  logic                   exp_edge_i,
    // {memory_read, memory_write, io_read_io, io_read_out, io_write_io, io_write_out}
    input  logic [5:0]             strobes_n_i,
    input  logic                   eop_out_n_i,
    input  logic                   hold_request_i,
    input  logic                   address_enable_i,
    input  logic                   address_strobe_i,
    input  logic                   lock_bus_control_i,
    input  logic                   next_word_i,
    input  dma_pkg::channel_mask_t dma_acknowledge_i,
    input  dma_pkg::channel_num_t  dma_rotate_i,
    input  dma_pkg::channel_mask_t edge_request_i,
    output int                     error_count_o,
    output int                     check_count_o
);
    import dma_pkg::*;

    logic [5:0]    strobes_q = 6'h3f;
    logic          eop_n_q = 1'b1;
    logic          lock_q = 1'b0;
    int            mem_read_falls = 0;
    int            mem_write_falls = 0;
    int            io_read_falls = 0;
    int            io_write_falls = 0;
    int            eop_falls = 0;
    int            errors = 0;
    int            checks = 0;
    channel_mask_t granted;
    channel_mask_t dack_expected;

    assign granted       = channel_mask_t'(1) << exp_channel_i;
    assign dack_expected = exp_dack_high_i ? granted : ~granted;
    assign error_count_o = errors;
    assign check_count_o = checks;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clock) begin
        strobes_q <= strobes_n_i;
        eop_n_q   <= eop_out_n_i;
        lock_q    <= lock_bus_control_i;

        // New grant starts with fresh edge counts
        if (lock_bus_control_i && !lock_q) begin
            mem_read_falls  = 0;
            mem_write_falls = 0;
            io_read_falls   = 0;
            io_write_falls  = 0;
            eop_falls       = 0;
        end else begin
            if (strobes_q[5] && !strobes_n_i[5]) mem_read_falls++;
            if (strobes_q[4] && !strobes_n_i[4]) mem_write_falls++;
            if (strobes_q[2] && !strobes_n_i[2]) io_read_falls++;
            if (strobes_q[0] && !strobes_n_i[0]) io_write_falls++;
            if (eop_n_q && !eop_out_n_i) eop_falls++;
        end

        if (next_word_i) begin
            compare_value("dma_acknowledge_o", 32'(dack_expected), 32'(dma_acknowledge_i));
        end

        // Grant over, compare totals
        if (!lock_bus_control_i && lock_q) begin
            compare_value("memory_read_n_o falls", exp_mem_read_i, mem_read_falls);
            compare_value("memory_write_n_o falls", exp_mem_write_i, mem_write_falls);
            compare_value("io_read_n_out_o falls", exp_io_read_i, io_read_falls);
            compare_value("io_write_n_out_o falls", exp_io_write_i, io_write_falls);
            compare_value("end_of_process_n_o pulses", exp_eop_i, eop_falls);
            compare_value("hold_request_o", 32'(1'b0), 32'(hold_request_i));
            compare_value("dma_rotate_o", 32'(exp_channel_i), 32'(dma_rotate_i));
            compare_value("edge_request_o", 32'(exp_edge_i),
                          32'(edge_request_i[exp_channel_i]));
        end

        if (check_idle_i) begin
            compare_value("read and write strobes", 32'h3f, 32'(strobes_n_i));
            compare_value("end_of_process_n_o", 32'(1'b1), 32'(eop_out_n_i));
            compare_value("hold_request_o", 32'(1'b0), 32'(hold_request_i));
            compare_value("address_enable_o", 32'(1'b0), 32'(address_enable_i));
            compare_value("address_strobe_o", 32'(1'b0), 32'(address_strobe_i));
            compare_value("lock_bus_control_o", 32'(1'b0), 32'(lock_bus_control_i));
            compare_value("next_word_o", 32'(1'b0), 32'(next_word_i));
            compare_value("dma_acknowledge_o", 32'hf, 32'(dma_acknowledge_i));
            compare_value("dma_rotate_o", 32'd3, 32'(dma_rotate_i));
            compare_value("edge_request_o", 32'h0, 32'(edge_request_i));
        end
    end

endmodule

// ==== bench/dma_timing_tb.sv ====
module dma_timing_tb;
    import dma_pkg::*;

    localparam int NUM_ROWS = 8;

    typedef struct packed {
        channel_num_t channel;
        xfer_type_t   xfer_type;
        xfer_mode_t   xfer_mode;
        data_t        command;
        int           words;
        logic         ready_delay;
        logic         ext_eop;
        int           mem_read;
        int           mem_write;
        int           io_read;
        int           io_write;
        int           eop_pulses;
        logic         dack_high;
        logic         edge_req;
    } row_t;

    logic          clock = 1'b0;
    logic          reset = 1'b1;
    logic          cpu_posedge_i = 1'b0;
    logic          cpu_negedge_i = 1'b0;
    logic          master_clear_i = 1'b0;
    data_t         data_bus_i = '0;
    logic          write_command_i = 1'b0;
    logic          write_mode_i = 1'b0;
    channel_mask_t encoded_dma_i = '0;
    channel_mask_t dma_request_state_i = '0;
    logic          hold_acknowledge_i = 1'b0;
    logic          ready_i = 1'b1;
    logic          end_of_process_n_i = 1'b1;
    logic          underflow_i = 1'b0;

    logic          hold_request_o;
    channel_mask_t dma_acknowledge_o;
    logic          address_enable_o;
    logic          address_strobe_o;
    logic          memory_read_n_o;
    logic          memory_write_n_o;
    logic          io_read_n_io_o;
    logic          io_read_n_out_o;
    logic          io_write_n_io_o;
    logic          io_write_n_out_o;
    logic          end_of_process_n_o;
    logic          next_word_o;
    channel_mask_t edge_request_o;
    channel_num_t  dma_rotate_o;
    logic          lock_bus_control_o;

    logic [1:0]    phase = 2'd0;
    logic [2:0]    hold_delay = 3'd0;
    logic          check_idle = 1'b0;
    int            words_done = 0;
    int            seed = 64474;
    int            error_count;
    int            check_count;
    row_t          row = '0;
    row_t          table_rows [NUM_ROWS];

    dma_timing_top UUT (.*);

    dma_timing_checker u_checker (
        .clock, .check_idle_i (check_idle), .exp_channel_i (row.channel),
        .exp_dack_high_i (row.dack_high), .exp_mem_read_i (row.mem_read),
        .exp_mem_write_i (row.mem_write), .exp_io_read_i (row.io_read),
        .exp_io_write_i (row.io_write), .exp_eop_i (row.eop_pulses),
        .exp_edge_i (row.edge_req),
        .strobes_n_i ({memory_read_n_o, memory_write_n_o, io_read_n_io_o,
                       io_read_n_out_o, io_write_n_io_o, io_write_n_out_o}),
        .eop_out_n_i (end_of_process_n_o), .hold_request_i (hold_request_o),
        .address_enable_i (address_enable_o), .address_strobe_i (address_strobe_o),
        .lock_bus_control_i (lock_bus_control_o), .next_word_i (next_word_o),
        .dma_acknowledge_i (dma_acknowledge_o), .dma_rotate_i (dma_rotate_o),
        .edge_request_i (edge_request_o),
        .error_count_o (error_count), .check_count_o (check_count)
    );

    always #10 clock = ~clock;

    // CPU clock edges, one CPU period is four clocks
    always @(posedge clock) begin
        phase         <= phase + 2'd1;
        cpu_posedge_i <= (phase == 2'd3);
        cpu_negedge_i <= (phase == 2'd1);
    end

    always @(posedge clock) begin
        hold_delay         <= {hold_delay[1:0], hold_request_o};
        hold_acknowledge_i <= hold_delay[2];
    end

    // Word counter, ready and external EOP change only with the FSM step
    always @(posedge clock) begin
        if (!lock_bus_control_o) begin
            words_done = 0;
            underflow_i        <= (row.words <= 1);
            end_of_process_n_i <= 1'b1;
            ready_i            <= 1'b1;
        end else if (phase == 2'd2) begin
            if (next_word_o) words_done = words_done + 1;
            underflow_i <= (words_done >= row.words - 1);
            if (row.ext_eop && (words_done == 2)) end_of_process_n_i <= 1'b0;
            ready_i <= row.ready_delay ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

    task automatic load_table();
        // channel, type, mode, command, words, ready delay, ext EOP,
        // mem read, mem write, io read, io write, EOP pulses, DACK level, edge request
        table_rows[0] = '{2'd0, XFER_READ, MODE_SINGLE, 8'h00, 4, 1'b0, 1'b0,
                          1, 0, 0, 1, 0, 1'b0, 1'b1};
        table_rows[1] = '{2'd1, XFER_WRITE, MODE_BLOCK, 8'h00, 4, 1'b0, 1'b0,
                          0, 4, 4, 0, 1, 1'b0, 1'b1};
        table_rows[2] = '{2'd2, XFER_VERIFY, MODE_BLOCK, 8'h80, 3, 1'b0, 1'b0,
                          0, 0, 0, 0, 1, 1'b1, 1'b1};
        table_rows[3] = '{2'd3, XFER_READ, MODE_BLOCK, 8'h08, 5, 1'b1, 1'b0,
                          5, 0, 0, 5, 1, 1'b0, 1'b1};
        table_rows[4] = '{2'd1, XFER_READ, MODE_BLOCK, 8'h20, 6, 1'b0, 1'b1,
                          3, 0, 0, 3, 0, 1'b0, 1'b1};
        table_rows[5] = '{2'd2, XFER_WRITE, MODE_SINGLE, 8'h00, 1, 1'b1, 1'b0,
                          0, 1, 1, 0, 1, 1'b0, 1'b1};
        table_rows[6] = '{2'd3, XFER_WRITE, MODE_BLOCK, 8'h28, 2, 1'b0, 1'b0,
                          0, 2, 2, 0, 1, 1'b0, 1'b1};
        table_rows[7] = '{2'd0, XFER_WRITE, MODE_DEMAND, 8'h88, 3, 1'b1, 1'b0,
                          0, 3, 3, 0, 1, 1'b1, 1'b0};
    endtask

    task automatic request_idle_check();
        @(posedge clock);
        check_idle <= 1'b1;
        @(posedge clock);
        check_idle <= 1'b0;
    endtask

    task automatic run_row(input row_t r);
        @(posedge clock);
        row             <= r;
        data_bus_i      <= r.command;
        write_command_i <= 1'b1;
        @(posedge clock);
        write_command_i <= 1'b0;
        write_mode_i    <= 1'b1;
        data_bus_i      <= {r.xfer_mode, 2'b00, r.xfer_type, r.channel};
        @(posedge clock);
        write_mode_i        <= 1'b0;
        encoded_dma_i       <= channel_mask_t'(1) << r.channel;
        dma_request_state_i <= channel_mask_t'(1) << r.channel;
        // Priority block drops the winner once the cycle is running
        do @(posedge clock); while (!lock_bus_control_o);
        encoded_dma_i <= '0;
        do @(posedge clock); while (lock_bus_control_o);
        dma_request_state_i <= '0;
        repeat (8) @(posedge clock);
    endtask

    initial begin
        load_table();
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        repeat (4) @(posedge clock);
        request_idle_check();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(table_rows[i]);
        end
        @(posedge clock);
        master_clear_i <= 1'b1;
        @(posedge clock);
        master_clear_i <= 1'b0;
        request_idle_check();
        repeat (4) @(posedge clock);
        $display("Finished with %0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (NUM_ROWS * 400) @(posedge clock);
        $display("Watchdog expired, the transfers did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== build.f ====
src/dma_pkg.sv
src/dma_config_regs.sv
src/dma_cycle_fsm.sv
src/dma_end_of_process.sv
src/dma_bus_strobes.sv
src/dma_timing_top.sv
bench/dma_timing_checker.sv
bench/dma_timing_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module dma_timing_tb -o dma_timing_sim
./obj_dir/dma_timing_sim > sim.log
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
exit 0
